//--- filelist.f
source/net_pkg.sv
source/msg_pkg.sv
source/stream_fifo.sv
source/udp_port_filter.sv
source/payload_exchanger.sv
source/udp_echo_top.sv
test/udp_echo_tb.sv

//--- Bender.yml
package:
  name: udp_echo

sources:
  - files:
      - source/net_pkg.sv
      - source/msg_pkg.sv
      - source/stream_fifo.sv
      - source/udp_port_filter.sv
      - source/payload_exchanger.sv
      - source/udp_echo_top.sv
  - target: test
    files:
      - test/udp_echo_tb.sv

//--- test/udp_echo_tb.sv
`timescale 1ns/1ps

module udp_echo_tb;

    import net_pkg::*;
    import msg_pkg::*;

    localparam int        BUFFER_BITS    = 64;
    localparam int        TIMEOUT_CYCLES = 300;
    localparam int        BUF_BYTES      = BUFFER_BITS / 8;
    localparam int        WAIT_LIMIT     = 1000;
    localparam udp_port_t PORT           = DEFAULT_LOCAL_PORT;

    logic                   clk;
    logic                   rst;
    logic                   rx_hdr_valid;
    logic                   rx_hdr_ready;
    ip_addr_t               rx_src_ip;
    udp_port_t              rx_src_port;
    udp_port_t              rx_dst_port;
    udp_len_t               rx_length;
    byte_t                  rx_payload_data;
    logic                   rx_payload_valid;
    logic                   rx_payload_ready;
    logic                   rx_payload_last;
    logic                   rx_payload_user;
    logic                   tx_hdr_valid;
    logic                   tx_hdr_ready;
    ip_addr_t               tx_dst_ip;
    udp_port_t              tx_src_port;
    udp_port_t              tx_dst_port;
    udp_len_t               tx_length;
    byte_t                  tx_payload_data;
    logic                   tx_payload_valid;
    logic                   tx_payload_ready;
    logic                   tx_payload_last;
    logic                   tx_payload_user;
    logic [BUFFER_BITS-1:0] tx_data;
    logic [BUFFER_BITS-1:0] rx_data;
    logic                   sync;
    logic                   pkg_timeout;

    // Reference model
    reply_hdr_t             hdr_q[$];
    logic [1:0]             flag_q[$];
    logic [BUFFER_BITS:0]   msg_q[$];
    byte_t                  frame_q[$];
    logic [BUFFER_BITS-1:0] frame_msg;
    logic [BUFFER_BITS-1:0] held_tx;
    logic [BUFFER_BITS-1:0] rx_exp;
    logic [BUFFER_BITS-1:0] rx_kept;
    logic                   sync_exp;
    logic                   rand_ready;
    int                     byte_idx;
    int                     wd_model;
    int                     errors;
    int                     errors_before;
    int                     tests_run;
    int                     tests_failed;
    int                     sync_seen;
    int                     tx_seen;
    int                     cycles;

    udp_echo_top #(
        .BUFFER_BITS   (BUFFER_BITS),
        .MSG_ID        (DEFAULT_MSG_ID),
        .LOCAL_PORT    (PORT),
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
        .PAYLOAD_DEPTH (64),
        .HDR_DEPTH     (4)
    ) u_udp_echo_top (
        .clk(clk), .rst(rst),
        .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready),
        .rx_src_ip(rx_src_ip), .rx_src_port(rx_src_port),
        .rx_dst_port(rx_dst_port), .rx_length(rx_length),
        .rx_payload_data(rx_payload_data), .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready), .rx_payload_last(rx_payload_last),
        .rx_payload_user(rx_payload_user),
        .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
        .tx_dst_ip(tx_dst_ip), .tx_src_port(tx_src_port),
        .tx_dst_port(tx_dst_port), .tx_length(tx_length),
        .tx_payload_data(tx_payload_data), .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready), .tx_payload_last(tx_payload_last),
        .tx_payload_user(tx_payload_user),
        .tx_data(tx_data), .rx_data(rx_data), .sync(sync), .pkg_timeout(pkg_timeout)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic note_error(input string what);
        errors++;
        $display("Fail %0t: %s", $time, what);
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    assert property (@(posedge clk) disable iff (rst) sync |=> !sync)
        else note_error("sync high for more than one cycle");
    assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid)
        else note_error("tx_payload_valid dropped before its transfer");
    assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_dst_ip))
        else note_error("reply header changed before its transfer");

    // Ready pattern and transmit word for the back-pressure test
    always @(posedge clk) begin
        #10;
        if (rand_ready) begin
            tx_payload_ready = 1'($urandom);
            tx_hdr_ready     = 1'($urandom);
            tx_data          = {$urandom, $urandom};
        end else begin
            tx_payload_ready = 1'b1;
            tx_hdr_ready     = 1'b1;
        end
    end

    always @(posedge clk) begin : reply_monitor
        reply_hdr_t           exp_hdr;
        logic [1:0]           flags;
        logic [BUFFER_BITS:0] msg;
        byte_t                exp_byte;
        logic                 next_sync;
        next_sync = 1'b0;
        if (rst) begin
            sync_exp = 1'b0;
            rx_exp   = '0;
            wd_model = 0;
            byte_idx = 0;
        end else begin
            assert (sync === sync_exp) else note_error("sync does not follow the message rule");
            assert (rx_data === rx_exp) else note_error("rx_data differs from the last message");
            assert (pkg_timeout === (wd_model == TIMEOUT_CYCLES))
                else note_error("pkg_timeout differs from the watchdog count");
            if (sync) sync_seen++;
            if (tx_hdr_valid || tx_payload_valid) tx_seen++;
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    note_error("reply header without a matching frame");
                end else begin
                    exp_hdr = hdr_q.pop_front();
                    assert (tx_dst_ip === exp_hdr.dst_ip && tx_src_port === exp_hdr.src_port
                            && tx_dst_port === exp_hdr.dst_port && tx_length === exp_hdr.length)
                        else note_error("reply header fields are wrong");
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (byte_idx == 0) held_tx = tx_data;
                exp_byte = (byte_idx < BUF_BYTES) ? held_tx[BUFFER_BITS-1-8*byte_idx -: 8] : 8'h00;
                if (flag_q.size() == 0) begin
                    note_error("reply byte without a received beat");
                end else begin
                    flags = flag_q.pop_front();
                    assert (tx_payload_data === exp_byte && tx_payload_last === flags[1]
                            && tx_payload_user === flags[0])
                        else note_error($sformatf("reply byte %0d is wrong", byte_idx));
                end
                byte_idx++;
                if (tx_payload_last) begin
                    byte_idx = 0;
                    if (msg_q.size() == 0) begin
                        note_error("frame end without an expected message");
                    end else begin
                        msg       = msg_q.pop_front();
                        next_sync = msg[BUFFER_BITS];
                        if (next_sync) rx_exp = msg[BUFFER_BITS-1:0];
                    end
                end
            end
            sync_exp = next_sync;
            if (next_sync) wd_model = 0;
            else if (wd_model != TIMEOUT_CYCLES) wd_model++;
        end
    end

    task automatic reset_dut;
        rst = 1'b1;
        hdr_q.delete();
        flag_q.delete();
        msg_q.delete();
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        assert (!tx_hdr_valid && !tx_payload_valid && !sync && !pkg_timeout
                && !rx_payload_ready && rx_data === '0)
            else note_error("outputs not idle after reset");
    endtask

    // Random bytes with the identifier at byte id_at when id_at is not negative
    task automatic build_frame(input int len, input int id_at);
        frame_q.delete();
        frame_msg = '0;
        for (int i = 0; i < len; i++) begin
            frame_q.push_back(byte_t'($urandom));
        end
        if (id_at >= 0) begin
            for (int i = 0; i < 4; i++) begin
                frame_q[id_at + i] = 8'(DEFAULT_MSG_ID >> (24 - 8 * i));
            end
        end
        if (id_at != 0) frame_q[0] = 8'h00;
        for (int i = 0; i < BUF_BYTES && i < len; i++) begin
            frame_msg[BUFFER_BITS-1-8*i -: 8] = frame_q[i];
        end
    endtask

    task automatic send_frame(input udp_port_t dst_port, input logic last_user);
        int   guard;
        logic ok;
        rx_src_ip    = $urandom;
        rx_src_port  = udp_port_t'($urandom);
        rx_dst_port  = dst_port;
        rx_length    = udp_len_t'(8 + frame_q.size());
        rx_hdr_valid = 1'b1;
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
        end while (!rx_hdr_ready && guard < WAIT_LIMIT);
        if (!rx_hdr_ready) abort_run("header was never accepted");
        ok = frame_q.size() >= BUF_BYTES && !last_user
             && frame_msg[BUFFER_BITS-1 -: 32] == DEFAULT_MSG_ID;
        if (dst_port == PORT) begin
            hdr_q.push_back(reply_hdr_t'{dst_ip: rx_src_ip, src_port: dst_port,
                                         dst_port: rx_src_port, length: rx_length});
            msg_q.push_back({ok, frame_msg});
        end
        #10;
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < frame_q.size(); i++) begin
            rx_payload_data  = frame_q[i];
            rx_payload_last  = (i == frame_q.size() - 1);
            rx_payload_user  = rx_payload_last && last_user;
            rx_payload_valid = 1'b1;
            guard = 0;
            do begin
                @(posedge clk);
                guard++;
            end while (!rx_payload_ready && guard < WAIT_LIMIT);
            if (!rx_payload_ready) abort_run("payload beat was never accepted");
            if (dst_port == PORT) flag_q.push_back({rx_payload_last, rx_payload_user});
            #10;
        end
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
    endtask

    task automatic wait_drained;
        int guard;
        guard = 0;
        while ((hdr_q.size() + flag_q.size() + msg_q.size()) != 0 && guard < WAIT_LIMIT) begin
            @(posedge clk);
            guard++;
        end
        if (guard >= WAIT_LIMIT) abort_run("replies never left the DUT");
        @(posedge clk);
        #10;
    endtask

    task automatic begin_test;
        errors_before = errors;
        sync_seen     = 0;
        tx_seen       = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    initial begin
        void'($urandom(32'h53c4871d));
        rst              = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_src_ip        = '0;
        rx_src_port      = '0;
        rx_dst_port      = '0;
        rx_length        = '0;
        rx_payload_data  = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        tx_data          = 64'h0123456789abcdef;
        rand_ready       = 1'b0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        reset_dut();

        begin_test();
        build_frame(12, 0);
        send_frame(PORT, 1'b0);
        wait_drained();
        assert (sync_seen == 1 && rx_data === frame_msg) else note_error("message not published");
        rx_kept = frame_msg;
        end_test("valid message");

        begin_test();
        build_frame(10, 0);
        send_frame(PORT + 16'd1, 1'b0);
        repeat (200) @(posedge clk);
        #10;
        assert (tx_seen == 0 && sync_seen == 0) else note_error("foreign port got a reply");
        end_test("port filter");

        begin_test();
        tx_data = 64'hfedcba9876543210;
        // Identifier at byte 4 lines up with the short frame that follows
        build_frame(12, 4);
        send_frame(PORT, 1'b0);
        build_frame(4, 0);
        send_frame(PORT, 1'b0);
        build_frame(12, 0);
        send_frame(PORT, 1'b1);
        wait_drained();
        assert (sync_seen == 0 && rx_data === rx_kept) else note_error("bad message accepted");
        end_test("rejected messages");

        begin_test();
        rand_ready = 1'b1;
        for (int f = 0; f < 3; f++) begin
            build_frame(8 + 5 * f, 0);
            send_frame(PORT, 1'b0);
        end
        wait_drained();
        rand_ready = 1'b0;
        assert (sync_seen == 3) else note_error("frames lost under back-pressure");
        end_test("back-pressure");

        begin_test();
        reset_dut();
        cycles = 0;
        while (!pkg_timeout && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (!pkg_timeout) abort_run("pkg_timeout never rose");
        assert (cycles == TIMEOUT_CYCLES) else note_error("pkg_timeout rose at the wrong cycle");
        build_frame(12, 0);
        send_frame(PORT, 1'b0);
        wait_drained();
        assert (sync_seen == 1 && !pkg_timeout) else note_error("watchdog not cleared");
        end_test("watchdog");

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- source/udp_echo_top.sv
`timescale 1ns/1ps

module udp_echo_top #(
    parameter int                 BUFFER_BITS    = msg_pkg::DEFAULT_BUFFER_BITS,
    parameter msg_pkg::msg_id_t   MSG_ID         = msg_pkg::DEFAULT_MSG_ID,
    parameter net_pkg::udp_port_t LOCAL_PORT     = net_pkg::DEFAULT_LOCAL_PORT,
    parameter int                 TIMEOUT_CYCLES = 4800000,
    parameter int                 PAYLOAD_DEPTH  = 1024,
    parameter int                 HDR_DEPTH      = 4
) (
    input  logic                   clk,
    input  logic                   rst,

    // Received UDP header and payload
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  net_pkg::ip_addr_t      rx_src_ip,
    input  net_pkg::udp_port_t     rx_src_port,
    input  net_pkg::udp_port_t     rx_dst_port,
    input  net_pkg::udp_len_t      rx_length,
    input  msg_pkg::byte_t         rx_payload_data,
    input  logic                   rx_payload_valid,
    output logic                   rx_payload_ready,
    input  logic                   rx_payload_last,
    input  logic                   rx_payload_user,

    // Reply UDP header and payload
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output net_pkg::ip_addr_t      tx_dst_ip,
    output net_pkg::udp_port_t     tx_src_port,
    output net_pkg::udp_port_t     tx_dst_port,
    output net_pkg::udp_len_t      tx_length,
    output msg_pkg::byte_t         tx_payload_data,
    output logic                   tx_payload_valid,
    input  logic                   tx_payload_ready,
    output logic                   tx_payload_last,
    output logic                   tx_payload_user,

    input  logic [BUFFER_BITS-1:0] tx_data,
    output logic [BUFFER_BITS-1:0] rx_data,
    output logic                   sync,
    output logic                   pkg_timeout
);

    import net_pkg::*;
    import msg_pkg::*;

    logic          hdr_push;
    logic          hdr_full;
    logic          hdr_empty;
    reply_hdr_t    hdr_in;
    reply_hdr_t    hdr_out;
    logic          beat_push;
    logic          beat_pop;
    logic          beat_full;
    logic          beat_empty;
    payload_beat_t beat_in;
    payload_beat_t beat_out;

    assign tx_hdr_valid = !hdr_empty;
    assign tx_dst_ip    = hdr_out.dst_ip;
    assign tx_src_port  = hdr_out.src_port;
    assign tx_dst_port  = hdr_out.dst_port;
    assign tx_length    = hdr_out.length;

    udp_port_filter #(
        .LOCAL_PORT(LOCAL_PORT)
    ) u_udp_port_filter (
        .clk             (clk),
        .rst             (rst),
        .rx_hdr_valid    (rx_hdr_valid),
        .rx_hdr_ready    (rx_hdr_ready),
        .rx_src_ip       (rx_src_ip),
        .rx_src_port     (rx_src_port),
        .rx_dst_port     (rx_dst_port),
        .rx_length       (rx_length),
        .rx_payload_data (rx_payload_data),
        .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .rx_payload_last (rx_payload_last),
        .rx_payload_user (rx_payload_user),
        .hdr_full        (hdr_full),
        .hdr_push        (hdr_push),
        .hdr_entry       (hdr_in),
        .beat_full       (beat_full),
        .beat_push       (beat_push),
        .beat_entry      (beat_in)
    );

    stream_fifo #(
        .entry_t(reply_hdr_t),
        .DEPTH  (HDR_DEPTH)
    ) u_hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (hdr_push),
        .push_entry(hdr_in),
        .pop       (tx_hdr_valid && tx_hdr_ready),
        .pop_entry (hdr_out),
        .full      (hdr_full),
        .empty     (hdr_empty)
    );

    stream_fifo #(
        .entry_t(payload_beat_t),
        .DEPTH  (PAYLOAD_DEPTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (beat_push),
        .push_entry(beat_in),
        .pop       (beat_pop),
        .pop_entry (beat_out),
        .full      (beat_full),
        .empty     (beat_empty)
    );

    payload_exchanger #(
        .BUFFER_BITS   (BUFFER_BITS),
        .MSG_ID        (MSG_ID),
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) u_payload_exchanger (
        .clk             (clk),
        .rst             (rst),
        .beat_empty      (beat_empty),
        .beat_entry      (beat_out),
        .beat_pop        (beat_pop),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready),
        .tx_payload_data (tx_payload_data),
        .tx_payload_last (tx_payload_last),
        .tx_payload_user (tx_payload_user),
        .tx_data         (tx_data),
        .rx_data         (rx_data),
        .sync            (sync),
        .pkg_timeout     (pkg_timeout)
    );

endmodule

//--- source/payload_exchanger.sv
`timescale 1ns/1ps

module payload_exchanger #(
    parameter int               BUFFER_BITS    = msg_pkg::DEFAULT_BUFFER_BITS,
    parameter msg_pkg::msg_id_t MSG_ID         = msg_pkg::DEFAULT_MSG_ID,
    parameter int               TIMEOUT_CYCLES = 4800000
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   beat_empty,
    input  msg_pkg::payload_beat_t beat_entry,
    output logic                   beat_pop,

    output logic                   tx_payload_valid,
    input  logic                   tx_payload_ready,
    output msg_pkg::byte_t         tx_payload_data,
    output logic                   tx_payload_last,
    output logic                   tx_payload_user,

    input  logic [BUFFER_BITS-1:0] tx_data,
    output logic [BUFFER_BITS-1:0] rx_data,
    output logic                   sync,
    output logic                   pkg_timeout
);

    import msg_pkg::*;

    localparam int BUF_BYTES = BUFFER_BITS / 8;
    localparam int CNT_W     = $clog2(BUF_BYTES + 1);
    localparam int WD_W      = (TIMEOUT_CYCLES > 0) ? $clog2(TIMEOUT_CYCLES + 1) : 1;

    logic [CNT_W-1:0]       byte_cnt;
    logic [BUFFER_BITS-1:0] tx_shift;
    logic [BUFFER_BITS-1:0] rx_shift;
    logic [BUFFER_BITS-1:0] rx_next;
    logic [BUFFER_BITS-1:0] captured;
    logic [WD_W-1:0]        wd_cnt;
    byte_t                  rx_byte;
    logic                   xfer;
    logic                   first_byte;
    logic                   in_window;
    logic                   long_enough;
    logic                   msg_ok;

    assign tx_payload_valid = !beat_empty;
    assign xfer             = tx_payload_valid && tx_payload_ready;
    assign beat_pop         = xfer;

    assign first_byte  = (byte_cnt == '0);
    assign in_window   = (byte_cnt < CNT_W'(BUF_BYTES));
    assign long_enough = (byte_cnt >= CNT_W'(BUF_BYTES - 1));

    // Byte 0 comes straight from tx_data, the rest from the shifted copy
    assign tx_payload_data = first_byte ? tx_data[BUFFER_BITS-1 -: 8]
                                        : tx_shift[BUFFER_BITS-1 -: 8];
    assign tx_payload_last = beat_entry.last;
    assign tx_payload_user = beat_entry.user;

    assign rx_byte  = beat_entry.data;
    assign rx_next  = {rx_shift[BUFFER_BITS-9:0], rx_byte};
    assign captured = in_window ? rx_next : rx_shift;

    assign msg_ok = xfer && beat_entry.last && !beat_entry.user && long_enough
                    && (captured[BUFFER_BITS-1 -: 32] == MSG_ID);

    assign pkg_timeout = (wd_cnt == WD_W'(TIMEOUT_CYCLES));

    // Zero fill so bytes past the buffer go out as zero
    always_ff @(posedge clk) begin
        if (xfer) begin
            if (first_byte) begin
                tx_shift <= {tx_data[BUFFER_BITS-9:0], 8'd0};
            end else begin
                tx_shift <= {tx_shift[BUFFER_BITS-9:0], 8'd0};
            end
            if (in_window) begin
                rx_shift <= rx_next;
            end
        end
    end

    // Saturates once the buffer is full
    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= '0;
        end else if (xfer) begin
            if (beat_entry.last) begin
                byte_cnt <= '0;
            end else if (in_window) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_data <= '0;
            sync    <= 1'b0;
            wd_cnt  <= '0;
        end else begin
            sync <= msg_ok;
            if (msg_ok) begin
                rx_data <= captured;
                wd_cnt  <= '0;
            end else if (!pkg_timeout) begin
                wd_cnt <= wd_cnt + 1'b1;
            end
        end
    end

endmodule

//--- source/udp_port_filter.sv
`timescale 1ns/1ps

module udp_port_filter #(
    parameter net_pkg::udp_port_t LOCAL_PORT = net_pkg::DEFAULT_LOCAL_PORT
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  net_pkg::ip_addr_t      rx_src_ip,
    input  net_pkg::udp_port_t     rx_src_port,
    input  net_pkg::udp_port_t     rx_dst_port,
    input  net_pkg::udp_len_t      rx_length,

    input  msg_pkg::byte_t         rx_payload_data,
    input  logic                   rx_payload_valid,
    output logic                   rx_payload_ready,
    input  logic                   rx_payload_last,
    input  logic                   rx_payload_user,

    input  logic                   hdr_full,
    output logic                   hdr_push,
    output net_pkg::reply_hdr_t    hdr_entry,

    input  logic                   beat_full,
    output logic                   beat_push,
    output msg_pkg::payload_beat_t beat_entry
);

    import net_pkg::*;
    import msg_pkg::*;

    typedef enum logic {
        awaiting_hdr,
        in_payload
    } frame_state_t;

    frame_state_t state;
    logic         match_reg;
    logic         port_match;
    logic         hdr_xfer;
    logic         payload_xfer;

    assign port_match = (rx_dst_port == LOCAL_PORT);

    // Matching headers need room for the reply, others are dropped at once
    assign rx_hdr_ready = (state == awaiting_hdr) && (!port_match || !hdr_full);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;
    assign hdr_push     = hdr_xfer && port_match;

    // Reply goes back where it came from
    assign hdr_entry = reply_hdr_t'{
        dst_ip:   rx_src_ip,
        src_port: rx_dst_port,
        dst_port: rx_src_port,
        length:   rx_length
    };

    // Non-matching frames are drained every cycle
    assign rx_payload_ready = (state == in_payload) && (!match_reg || !beat_full);
    assign payload_xfer     = rx_payload_valid && rx_payload_ready;
    assign beat_push        = payload_xfer && match_reg;

    assign beat_entry = payload_beat_t'{
        data: rx_payload_data,
        last: rx_payload_last,
        user: rx_payload_user
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= awaiting_hdr;
            match_reg <= 1'b0;
        end else begin
            case (state)
                awaiting_hdr: begin
                    if (hdr_xfer) begin
                        state     <= in_payload;
                        match_reg <= port_match;
                    end
                end
                in_payload: begin
                    if (payload_xfer && rx_payload_last) begin
                        state <= awaiting_hdr;
                    end
                end
                default: state <= awaiting_hdr;
            endcase
        end
    end

endmodule

//--- source/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  entry_t push_entry,
    input  logic   pop,
    output entry_t pop_entry,
    output logic   full,
    output logic   empty
);

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);

    entry_t            mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    // Pointer advance with wrap for depths that are not a power of two
    function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
        if (ptr == ADDR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign pop_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/msg_pkg.sv
package msg_pkg;

    typedef logic [7:0] byte_t;

    // One payload byte with its stream flags
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } payload_beat_t;

    typedef logic [31:0] msg_id_t;

    // ASCII "tirw"
    localparam msg_id_t DEFAULT_MSG_ID = 32'h74697277;

    localparam int DEFAULT_BUFFER_BITS = 64;

endpackage

//--- source/net_pkg.sv
package net_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Reply header as handed to the UDP/IP stack
    // Stack fills in TTL, DSCP, ECN, checksum and the local IP itself
    typedef struct packed {
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
    } reply_hdr_t;

    localparam udp_port_t DEFAULT_LOCAL_PORT = 16'd2390;

endpackage
